/* sources.f */
+incdir+hw
hw/bottom_pkg.sv
hw/bottom_incdec.sv
hw/bottom_irq.sv
hw/bottom_decode.sv
hw/bottom_execute.sv
hw/bottom_result.sv
hw/bottom_top.sv
sim/bottom_assert.sv
sim/bottom_tb.sv

/* Bender.yml */
package:
  name: bottom

sources:
  - include_dirs:
      - hw
    files:
      - hw/bottom_pkg.sv
      - hw/bottom_incdec.sv
      - hw/bottom_irq.sv
      - hw/bottom_decode.sv
      - hw/bottom_execute.sv
      - hw/bottom_result.sv
      - hw/bottom_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/bottom_assert.sv
      - sim/bottom_tb.sv

/* sim/bottom_tb.sv */
`timescale 1ns/1ps
`include "bottom_params.svh"

module bottom_tb
	import bottom_pkg::*;
();

	localparam int clk_period = 4;
	localparam int n_cmds = 52;
	// Four cycles per command, plus reset and the IRQ polling loops
	localparam int timeout_ns = (n_cmds * 4 + 120) * clk_period;

	logic clk;
	logic rst_n;
	logic ime;
	bot_cmd_t cmd;
	logic [`BOT_IRQ_N-1:0] irq_trig;
	logic [`BOT_IRQ_N-1:0] irq_ack;
	logic [`BOT_DATA_W-1:0] dl_out;
	logic [`BOT_ADDR_W-1:0] addr;
	logic dl_valid;
	logic addr_valid;
	logic irq_pending;
	logic early_dl_valid;	// Sampled one cycle before the result
	logic early_addr_valid;
	logic [7:0] ref_rf [0:8];	// Model of A..L, Z, W
	logic [7:0] ref_ie;
	logic [7:0] ref_flags;
	logic [15:0] ref_pc;

	bottom_top dut0 (.*);

	always #(clk_period / 2) clk = ~clk;

	initial begin
		#(timeout_ns);
		$display("Watchdog expired before the tests completed");
		$display("Test failures found");
		$fatal(1, "timeout");
	end

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Test failures found");
		$fatal(1, "stopping at first error");
	endtask

	task automatic value_error(input string name, input logic [15:0] exp, input logic [15:0] got);
		$display("ERR %s exp=%h got=%h", name, exp, got);
		report_failure("value mismatch");
	endtask

	task automatic check_val(input string name, input logic [15:0] exp, input logic [15:0] got);
		assert (got === exp) else value_error(name, exp, got);
	endtask

	function automatic logic [15:0] step_ref(input logic [15:0] w, input logic down, input logic pw);
		logic [7:0] lo;
		logic [7:0] hi;
		logic cy;
		lo = down ? w[7:0] - 8'd1 : w[7:0] + 8'd1;
		cy = (down ? (w[7:0] == 8'h00) : (w[7:0] == 8'hFF)) | pw;	// Pairwise forces it
		hi = cy ? (down ? w[15:8] - 8'd1 : w[15:8] + 8'd1) : w[15:8];
		return {hi, lo};
	endfunction

	function automatic int lowest_set(input logic [7:0] f);
		for (int i = 0; i < 8; i++)
			if (f[i])
				return i;
		return -1;
	endfunction

	function automatic logic [15:0] vec_ref(input int idx);
		return `BOT_IRQ_BASE + 16'(idx * `BOT_IRQ_STEP);
	endfunction

	// Drives one command and returns once its result is on the outputs
	task automatic issue(input bot_op_e op, input bot_reg_e rsel, input bot_pair_e pair,
		input logic pw, input logic [7:0] data);
		bot_cmd_t c;
		c = '0;
		c.valid = 1'b1;
		c.op = op;
		c.rsel = rsel;
		c.pair = pair;
		c.pairwise = pw;
		c.data = data;
		@(posedge clk);
		cmd <= c;
		@(posedge clk);
		cmd <= '0;
		@(posedge clk);
		@(negedge clk);
		early_dl_valid = dl_valid;
		early_addr_valid = addr_valid;
		@(posedge clk);
		@(negedge clk);
	endtask

	task automatic load_bytes(input bot_reg_e hi_r, input bot_reg_e lo_r, input logic [15:0] v);
		issue(OP_LD_REG, hi_r, PAIR_BC, 1'b0, v[15:8]);
		issue(OP_LD_REG, lo_r, PAIR_BC, 1'b0, v[7:0]);
		ref_rf[hi_r] = v[15:8];
		ref_rf[lo_r] = v[7:0];
	endtask

	task automatic byte_reg_test();
		logic [7:0] val;
		for (int i = 0; i <= 8; i++) begin
			val = 8'($urandom());
			ref_rf[i] = val;
			issue(OP_LD_REG, bot_reg_e'(i), PAIR_BC, 1'b0, val);
			check_val("dl_valid", 16'h0, dl_valid);
		end
		for (int i = 0; i <= 8; i++) begin
			issue(OP_RD_REG, bot_reg_e'(i), PAIR_BC, 1'b0, 8'h00);
			check_val("dl_valid(early)", 16'h0, early_dl_valid);	// Not before two cycles
			check_val("dl_valid", 16'h1, dl_valid);
			check_val("dl_out", ref_rf[i], dl_out);
		end
	endtask

	task automatic step_test(input bot_pair_e p, input bot_reg_e hi_r, input bot_reg_e lo_r,
		input logic [15:0] start, input logic down, input logic pw);
		logic [15:0] after;
		after = step_ref(start, down, pw);
		load_bytes(hi_r, lo_r, start);
		issue(down ? OP_DEC : OP_INC, REG_A, p, pw, 8'h00);
		check_val("addr_valid(early)", 16'h0, early_addr_valid);
		check_val("addr_valid", 16'h1, addr_valid);
		check_val("addr", start, addr);	// Pre-step value
		issue(OP_ADDR, REG_A, p, 1'b0, 8'h00);
		check_val("addr", after, addr);
		ref_rf[hi_r] = after[15:8];
		ref_rf[lo_r] = after[7:0];
	endtask

	task automatic ie_reg_test();
		logic [7:0] val;
		val = 8'($urandom());
		load_bytes(REG_W, REG_Z, 16'hFFFF);
		issue(OP_LD_PAIR_WZ, REG_A, PAIR_DE, 1'b0, 8'h00);
		ref_rf[REG_D] = 8'hFF;
		ref_rf[REG_E] = 8'hFF;
		issue(OP_ADDR, REG_A, PAIR_DE, 1'b0, 8'h00);
		check_val("addr", 16'hFFFF, addr);
		issue(OP_MEM_WR, REG_A, PAIR_DE, 1'b0, val);
		ref_ie = val;
		issue(OP_MEM_RD, REG_A, PAIR_DE, 1'b0, 8'h00);
		check_val("dl_valid", 16'h1, dl_valid);
		check_val("dl_out", ref_ie, dl_out);
		issue(OP_MEM_RD, REG_A, PAIR_BC, 1'b0, 8'h00);
		check_val("dl_out", `BOT_BUS_IDLE, dl_out);
	endtask

	task automatic wait_pending(input logic want, input int max_cycles);
		bit seen;
		seen = 1'b0;
		for (int n = 0; n < max_cycles && !seen; n++) begin
			@(negedge clk);
			if (irq_pending === want)
				seen = 1'b1;
		end
		assert (seen) else report_failure($sformatf("irq_pending did not reach %0b in %0d cycles",
			want, max_cycles));
	endtask

	task automatic take_check();
		int idx;
		logic [7:0] exp_ack;
		idx = (ime && ref_flags != 8'h00) ? lowest_set(ref_flags) : -1;
		exp_ack = (idx >= 0) ? 8'(1 << idx) : 8'h00;
		if (idx >= 0) begin
			ref_flags[idx] = 1'b0;
			ref_pc = vec_ref(idx);
		end
		issue(OP_IRQ_TAKE, REG_A, PAIR_PC, 1'b0, 8'h00);
		check_val("irq_ack", exp_ack, irq_ack);
		issue(OP_ADDR, REG_A, PAIR_PC, 1'b0, 8'h00);
		check_val("addr", ref_pc, addr);
	endtask

	task automatic irq_test();
		@(posedge clk);
		ime <= 1'b1;
		issue(OP_MEM_WR, REG_A, PAIR_DE, 1'b0, 8'h24);	// Enable sources 2 and 5
		ref_ie = 8'h24;
		@(posedge clk);
		irq_trig <= 8'h24;
		wait_pending(1'b1, 16);
		ref_flags = 8'h24 & ref_ie;
		@(posedge clk);
		irq_trig <= '0;
		take_check();
		take_check();
		@(posedge clk);
		ime <= 1'b0;
		irq_trig <= 8'h04;
		@(posedge clk);
		irq_trig <= '0;
		ref_flags = ref_flags | (8'h04 & ref_ie);
		wait_pending(1'b0, 16);
		take_check();	// Flag set but masked so PC stays put
	endtask

	initial begin
		void'($urandom(32'hfb41));
		clk = 1'b0;
		rst_n = 1'b0;
		cmd = '0;
		irq_trig = '0;
		ime = 1'b0;
		ref_ie = '0;
		ref_flags = '0;
		ref_pc = '0;
		for (int i = 0; i <= 8; i++)
			ref_rf[i] = '0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		byte_reg_test();
		step_test(PAIR_HL, REG_H, REG_L, 16'h00FF, 1'b0, 1'b0);
		step_test(PAIR_HL, REG_H, REG_L, 16'h0000, 1'b1, 1'b0);
		step_test(PAIR_BC, REG_B, REG_C, 16'h1234, 1'b0, 1'b1);
		step_test(PAIR_BC, REG_B, REG_C, 16'h1234, 1'b1, 1'b1);
		step_test(PAIR_BC, REG_B, REG_C, 16'h1234, 1'b0, 1'b0);
		ie_reg_test();
		irq_test();
		repeat (2) @(posedge clk);
		if (dut0.u_assert.fail_cnt == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

/* sim/bottom_assert.sv */
`timescale 1ns/1ps
`include "bottom_params.svh"

module bottom_assert (
	input logic clk,
	input logic rst_n,
	input logic ime,
	input logic dl_valid,
	input logic addr_valid,
	input logic [`BOT_IRQ_N-1:0] irq_ack
);

	int fail_cnt = 0;	// Read by the testbench at the end

	ack_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(irq_ack))
		else begin
			fail_cnt++;
			$error("irq_ack has more than one bit set");
		end

	// Ack leaves result two edges after ime was sampled in execute
	ack_needs_ime: assert property (@(posedge clk) disable iff (!rst_n)
		(irq_ack != '0) |-> $past(ime, 2))
		else begin
			fail_cnt++;
			$error("irq_ack raised although ime was low");
		end

	quiet_in_reset: assert property (@(posedge clk) !rst_n |-> (!dl_valid && !addr_valid))
		else begin
			fail_cnt++;
			$error("valid strobe active during reset");
		end

endmodule

bind bottom_top bottom_assert u_assert (
	.clk(clk),
	.rst_n(rst_n),
	.ime(ime),
	.dl_valid(dl_valid),
	.addr_valid(addr_valid),
	.irq_ack(irq_ack)
);

/* hw/bottom_top.sv */
`timescale 1ns/1ps
`include "bottom_params.svh"

module bottom_top
	import bottom_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input bot_cmd_t cmd,
	input logic [`BOT_IRQ_N-1:0] irq_trig,
	input logic ime,
	output logic [`BOT_DATA_W-1:0] dl_out,
	output logic dl_valid,
	output logic [`BOT_ADDR_W-1:0] addr,
	output logic addr_valid,
	output logic [`BOT_IRQ_N-1:0] irq_ack,
	output logic irq_pending
);

	bot_ctl_t ctl;
	logic [`BOT_DATA_W-1:0] wdata;
	bot_exec_t ex;

	bottom_decode u_decode (
		.clk(clk),
		.rst_n(rst_n),
		.cmd(cmd),
		.ctl(ctl),
		.wdata(wdata)
	);

	bottom_execute u_execute (
		.clk(clk),
		.rst_n(rst_n),
		.ctl(ctl),
		.wdata(wdata),
		.irq_trig(irq_trig),
		.ime(ime),
		.ex(ex),
		.irq_pending(irq_pending)
	);

	bottom_result u_result (
		.clk(clk),
		.rst_n(rst_n),
		.ex(ex),
		.dl_out(dl_out),
		.dl_valid(dl_valid),
		.addr(addr),
		.addr_valid(addr_valid),
		.irq_ack(irq_ack)
	);

endmodule

/* hw/bottom_result.sv */
`timescale 1ns/1ps
`include "bottom_params.svh"

module bottom_result
	import bottom_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input bot_exec_t ex,
	output logic [`BOT_DATA_W-1:0] dl_out,
	output logic dl_valid,
	output logic [`BOT_ADDR_W-1:0] addr,
	output logic addr_valid,
	output logic [`BOT_IRQ_N-1:0] irq_ack
);

	localparam int N = `BOT_IRQ_N;

	logic [`BOT_DATA_W-1:0] rd_mux;
	logic [N-1:0] ack_oh;

	// Memory space answers only at IE and reads as idle bus elsewhere
	always_comb begin
		if (ex.mem_rd)
			rd_mux = ex.ie_hit ? ex.ie : `BOT_BUS_IDLE;
		else
			rd_mux = ex.rd_byte;
	end

	assign ack_oh = ex.ack_valid ? (N'(1) << ex.ack_idx) : '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dl_out <= '0;
			dl_valid <= 1'b0;
			addr <= '0;
			addr_valid <= 1'b0;
			irq_ack <= '0;
		end else begin
			dl_out <= rd_mux;
			dl_valid <= ex.rd_valid;
			addr <= ex.addr;
			addr_valid <= ex.addr_valid;
			irq_ack <= ack_oh;	// Single-cycle pulse
		end
	end

endmodule

/* hw/bottom_execute.sv */
`timescale 1ns/1ps
`include "bottom_params.svh"

module bottom_execute
	import bottom_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input bot_ctl_t ctl,
	input logic [`BOT_DATA_W-1:0] wdata,
	input logic [`BOT_IRQ_N-1:0] irq_trig,
	input logic ime,
	output bot_exec_t ex,
	output logic irq_pending
);

	logic [`BOT_DATA_W-1:0] rf [0:REG_W];	// A..L, then Z and W
	bot_pair_u sp, pc;
	bot_pair_u sel, stepped, wz, wb;
	logic pair_wr;
	logic ie_wr;
	logic [`BOT_DATA_W-1:0] ie_val;
	logic pend;
	logic ack_valid;
	logic [`BOT_IRQ_IDX_W-1:0] ack_idx;
	logic [`BOT_ADDR_W-1:0] vector;
	bot_exec_t ex_d;

	always_comb begin
		wz.b.hi = rf[REG_W];
		wz.b.lo = rf[REG_Z];
		sel.word = '0;
		case (ctl.pair)
			PAIR_BC: begin
				sel.b.hi = rf[REG_B];
				sel.b.lo = rf[REG_C];
			end
			PAIR_DE: begin
				sel.b.hi = rf[REG_D];
				sel.b.lo = rf[REG_E];
			end
			PAIR_HL: begin
				sel.b.hi = rf[REG_H];
				sel.b.lo = rf[REG_L];
			end
			PAIR_WZ: sel = wz;
			PAIR_SP: sel = sp;
			PAIR_PC: sel = pc;
			default: sel.word = '0;
		endcase
	end

	bottom_incdec u_incdec (
		.word(sel),
		.step(ctl.step),
		.down(ctl.down),
		.pairwise(ctl.pairwise),
		.next(stepped)
	);

	assign pair_wr = ctl.step | ctl.ld_wz;
	assign wb = ctl.ld_wz ? wz : stepped;
	assign ie_wr = ctl.mem_wr & (sel.word == `BOT_IE_ADDR);	// Only 0xFFFF reaches IE

	bottom_irq u_irq (
		.clk(clk),
		.rst_n(rst_n),
		.ie_wr(ie_wr),
		.ie_data(wdata),
		.irq_trig(irq_trig),
		.take(ctl.irq_take),
		.ime(ime),
		.ie(ie_val),
		.pending(pend),
		.ack_valid(ack_valid),
		.ack_idx(ack_idx),
		.vector(vector)
	);

	always_comb begin
		ex_d.rd_valid = ctl.rd_en | ctl.mem_rd;
		ex_d.mem_rd = ctl.mem_rd;
		ex_d.rd_byte = (ctl.rsel <= REG_W) ? rf[ctl.rsel] : '0;
		ex_d.addr_valid = ctl.addr_drv;
		ex_d.addr = sel.word;	// Value before the step
		ex_d.ie_hit = (sel.word == `BOT_IE_ADDR);
		ex_d.ie = ie_val;
		ex_d.ack_valid = ack_valid;
		ex_d.ack_idx = ack_idx;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i <= REG_W; i++)
				rf[i] <= '0;
			sp <= '0;
			pc <= '0;
			ex <= '0;
			irq_pending <= 1'b0;
		end else begin
			if (ctl.reg_we && ctl.rsel <= REG_W)
				rf[ctl.rsel] <= wdata;
			if (pair_wr) begin
				case (ctl.pair)
					PAIR_BC: {rf[REG_B], rf[REG_C]} <= wb.word;
					PAIR_DE: {rf[REG_D], rf[REG_E]} <= wb.word;
					PAIR_HL: {rf[REG_H], rf[REG_L]} <= wb.word;
					PAIR_WZ: {rf[REG_W], rf[REG_Z]} <= wb.word;
					PAIR_SP: sp <= wb;
					PAIR_PC: pc <= wb;
					default: ;
				endcase
			end
			if (ack_valid)
				pc.word <= vector;	// Jump to the handler slot
			ex <= ex_d;
			irq_pending <= pend;
		end
	end

endmodule

/* hw/bottom_decode.sv */
`timescale 1ns/1ps
`include "bottom_params.svh"

module bottom_decode
	import bottom_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input bot_cmd_t cmd,
	output bot_ctl_t ctl,
	output logic [`BOT_DATA_W-1:0] wdata
);

	bot_ctl_t ctl_d;

	always_comb begin
		ctl_d = '0;
		if (cmd.valid) begin
			ctl_d.rsel = cmd.rsel;
			ctl_d.pair = cmd.pair;
			case (cmd.op)
				OP_LD_REG: ctl_d.reg_we = 1'b1;
				OP_RD_REG: ctl_d.rd_en = 1'b1;
				OP_INC, OP_DEC: begin
					ctl_d.step = 1'b1;
					ctl_d.down = (cmd.op == OP_DEC);
					ctl_d.pairwise = cmd.pairwise;
					ctl_d.addr_drv = 1'b1;	// Pre-step value on the bus
				end
				OP_ADDR: ctl_d.addr_drv = 1'b1;
				OP_LD_PAIR_WZ: begin
					ctl_d.ld_wz = 1'b1;
					ctl_d.addr_drv = 1'b1;
				end
				OP_MEM_WR: begin
					ctl_d.mem_wr = 1'b1;
					ctl_d.addr_drv = 1'b1;
				end
				OP_MEM_RD: begin
					ctl_d.mem_rd = 1'b1;
					ctl_d.addr_drv = 1'b1;
				end
				OP_IRQ_TAKE: ctl_d.irq_take = 1'b1;
				default: ctl_d = '0;	// NOP and unused codes
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctl <= '0;
			wdata <= '0;
		end else begin
			ctl <= ctl_d;
			wdata <= cmd.data;	// Byte travels with its enables
		end
	end

endmodule

/* hw/bottom_irq.sv */
`timescale 1ns/1ps
`include "bottom_params.svh"

module bottom_irq (
	input logic clk,
	input logic rst_n,
	input logic ie_wr,
	input logic [`BOT_DATA_W-1:0] ie_data,
	input logic [`BOT_IRQ_N-1:0] irq_trig,
	input logic take,
	input logic ime,
	output logic [`BOT_DATA_W-1:0] ie,
	output logic pending,
	output logic ack_valid,
	output logic [`BOT_IRQ_IDX_W-1:0] ack_idx,
	output logic [`BOT_ADDR_W-1:0] vector
);

	localparam int N = `BOT_IRQ_N;
	localparam int IW = `BOT_IRQ_IDX_W;
	localparam int AW = `BOT_ADDR_W;

	logic [N-1:0] if_q;	// Latched interrupt flags
	logic [N-1:0] clr;
	logic found;

	// Lowest pending index wins
	always_comb begin
		ack_idx = '0;
		found = 1'b0;
		for (int i = 0; i < N; i++) begin
			if (if_q[i] && !found) begin
				ack_idx = IW'(i);
				found = 1'b1;
			end
		end
	end

	assign pending = found & ime;
	assign ack_valid = take & ime & found;
	assign clr = ack_valid ? (N'(1) << ack_idx) : '0;
	assign vector = `BOT_IRQ_BASE + AW'(ack_idx) * AW'(`BOT_IRQ_STEP);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ie <= '0;
			if_q <= '0;
		end else begin
			if (ie_wr)
				ie <= ie_data;
			// Acknowledge wins over a trigger in the same cycle
			if_q <= (if_q | (irq_trig & ie[N-1:0])) & ~clr;
		end
	end

endmodule

/* hw/bottom_incdec.sv */
`timescale 1ns/1ps
`include "bottom_params.svh"

module bottom_incdec
	import bottom_pkg::*;
(
	input bot_pair_u word,
	input logic step,
	input logic down,
	input logic pairwise,
	output bot_pair_u next
);

	logic [`BOT_DATA_W-1:0] cy_lo;	// Carry into each low bit
	logic [`BOT_DATA_W-1:0] cy_hi;
	logic cy_mid;

	// A bit passes the carry on when it is 1 going up or 0 going down
	always_comb begin
		cy_lo[0] = step;
		for (int i = 1; i < `BOT_DATA_W; i++)
			cy_lo[i] = cy_lo[i-1] & (word.b.lo[i-1] ^ down);

		// Pairwise mode forces the high byte to step as well
		cy_mid = (cy_lo[`BOT_DATA_W-1] & (word.b.lo[`BOT_DATA_W-1] ^ down))
			| (step & pairwise);

		cy_hi[0] = cy_mid;
		for (int i = 1; i < `BOT_DATA_W; i++)
			cy_hi[i] = cy_hi[i-1] & (word.b.hi[i-1] ^ down);

		next.b.lo = word.b.lo ^ cy_lo;
		next.b.hi = word.b.hi ^ cy_hi;	// Top carry-out dropped
	end

endmodule

/* hw/bottom_pkg.sv */
`include "bottom_params.svh"

package bottom_pkg;

	typedef enum logic [3:0] {
		OP_NOP, OP_LD_REG, OP_RD_REG, OP_INC, OP_DEC, OP_ADDR,
		OP_LD_PAIR_WZ, OP_MEM_WR, OP_MEM_RD, OP_IRQ_TAKE
	} bot_op_e;

	typedef enum logic [3:0] {
		REG_A, REG_B, REG_C, REG_D, REG_E, REG_H, REG_L, REG_Z, REG_W
	} bot_reg_e;

	typedef enum logic [2:0] {
		PAIR_BC, PAIR_DE, PAIR_HL, PAIR_WZ, PAIR_SP, PAIR_PC
	} bot_pair_e;

	typedef struct packed {
		logic valid;
		bot_op_e op;
		bot_reg_e rsel;	// Byte register for LD_REG / RD_REG
		bot_pair_e pair;
		logic pairwise;	// Step both halves together
		logic [`BOT_DATA_W-1:0] data;
	} bot_cmd_t;

	typedef struct packed {
		logic reg_we;
		logic rd_en;
		bot_reg_e rsel;
		bot_pair_e pair;
		logic step;
		logic down;	// Decrement when set
		logic pairwise;
		logic ld_wz;	// Pair loaded from WZ
		logic addr_drv;	// Pair value onto address bus
		logic mem_wr;
		logic mem_rd;
		logic irq_take;
	} bot_ctl_t;

	// A pair is stepped as a word but loaded and read as bytes
	typedef union packed {
		logic [`BOT_ADDR_W-1:0] word;
		struct packed {
			logic [`BOT_DATA_W-1:0] hi;
			logic [`BOT_DATA_W-1:0] lo;
		} b;
	} bot_pair_u;

	typedef struct packed {
		logic rd_valid;
		logic mem_rd;	// Read goes to memory space, not a register
		logic [`BOT_DATA_W-1:0] rd_byte;
		logic addr_valid;
		logic [`BOT_ADDR_W-1:0] addr;
		logic ie_hit;
		logic [`BOT_DATA_W-1:0] ie;
		logic ack_valid;
		logic [`BOT_IRQ_IDX_W-1:0] ack_idx;
	} bot_exec_t;

endpackage

/* hw/bottom_params.svh */
`ifndef BOTTOM_PARAMS_SVH
`define BOTTOM_PARAMS_SVH

// Datapath widths
`define BOT_DATA_W 8
`define BOT_ADDR_W 16

// Interrupt sources and encoded index width
`define BOT_IRQ_N 8
`define BOT_IRQ_IDX_W 3

// IE register sits at the top of the address space
`define BOT_IE_ADDR 16'hFFFF

// Vector table starts at 0x0040 with one slot per 8 bytes
`define BOT_IRQ_BASE 16'h0040
`define BOT_IRQ_STEP 8

// Value left on the data bus when nothing drives it
`define BOT_BUS_IDLE 8'hFF

`endif
